// ==== riscvPipePkg.sv ====
////////////////////////////////////////////////////////////////////////////
// RISC-V pipeline definitions: widths, opcode and selector codes, the
// instruction union and the stage register structs
////////////////////////////////////////////////////////////////////////////
package riscvPipePkg;

    localparam int xlen = 32;
    localparam int regAddrBits = 5;
    localparam logic [xlen-1:0] pcStart = '0;

    // Opcodes seen by the execute stage
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;

    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;

    // Immediate formats
    localparam logic [2:0] immI = 3'd0;
    localparam logic [2:0] immS = 3'd1;
    localparam logic [2:0] immB = 3'd2;
    localparam logic [2:0] immJ = 3'd3;
    localparam logic [2:0] immU = 3'd4;

    localparam logic [1:0] fwdReg = 2'b00;
    localparam logic [1:0] fwdWb  = 2'b01;
    localparam logic [1:0] fwdMem = 2'b10;

    localparam logic [1:0] resAlu     = 2'b00;
    localparam logic [1:0] resMem     = 2'b01;
    localparam logic [1:0] resPcPlus4 = 2'b10;
    localparam logic [1:0] resImm     = 2'b11;

    localparam logic [2:0] aluAdd = 3'b000;
    localparam logic [2:0] aluSub = 3'b001;
    localparam logic [2:0] aluAnd = 3'b010;
    localparam logic [2:0] aluOr  = 3'b011;
    localparam logic [2:0] aluSlt = 3'b101;

    // Register view and store view of the same instruction word
    typedef union packed {
        struct packed {
            logic [6:0]             funct7;
            logic [regAddrBits-1:0] rs2;
            logic [regAddrBits-1:0] rs1;
            logic [2:0]             funct3;
            logic [regAddrBits-1:0] rd;
            logic [6:0]             opcode;
        } rView;
        struct packed {
            logic [6:0]             immHi;
            logic [regAddrBits-1:0] rs2;
            logic [regAddrBits-1:0] rs1;
            logic [2:0]             funct3;
            logic [4:0]             immLo;
            logic [6:0]             opcode;
        } sView;
    } instrT;

    typedef struct packed {
        instrT           instr;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] pcPlus4;
    } fetchRegT;

    typedef struct packed {
        logic [xlen-1:0]        rd1;
        logic [xlen-1:0]        rd2;
        logic [xlen-1:0]        pc;
        logic [xlen-1:0]        pcPlus4;
        logic [xlen-1:0]        extImm;
        logic [regAddrBits-1:0] rs1;
        logic [regAddrBits-1:0] rs2;
        logic [regAddrBits-1:0] rd;
        logic [6:0]             op;
        logic [2:0]             funct3;
    } execRegT;

    // Shared by the memory and writeback registers
    typedef struct packed {
        logic [xlen-1:0]        aluResult;
        logic [xlen-1:0]        writeData;
        logic [xlen-1:0]        extImm;
        logic [xlen-1:0]        pcPlus4;
        logic [regAddrBits-1:0] rd;
    } memRegT;

    typedef struct packed {
        logic       aluSrc;
        logic [2:0] aluControl;
        logic [1:0] forwardA;
        logic [1:0] forwardB;
    } exCtrlT;

    typedef struct packed {
        logic [1:0] resultSrcM;
        logic [1:0] resultSrcW;
        logic       regWriteW;
    } resCtrlT;

endpackage

// ==== pipeFetch.sv ====
////////////////////////////////////////////////////////////////////////////
// Fetch program counter with stall, not-taken stepping and redirect
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module pipeFetch (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           stallF_i,
    input  logic                           mispredict_i,
    input  logic [riscvPipePkg::xlen-1:0]  pcTarget_i,
    output logic [riscvPipePkg::xlen-1:0]  pcF_o,
    output logic [riscvPipePkg::xlen-1:0]  pcPlus4F_o
);

    // Every branch is predicted not taken
    assign pcPlus4F_o = pcF_o + 4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= riscvPipePkg::pcStart;
        end else if (!stallF_i) begin
            // Execute resolved a taken branch or a jump
            if (mispredict_i) begin
                pcF_o <= pcTarget_i;
            end else begin
                pcF_o <= pcPlus4F_o;
            end
        end
    end

endmodule

// ==== pipeDecode.sv ====
////////////////////////////////////////////////////////////////////////////
// Decode register with flush and stall, field outputs and immediate
// extension for the I, S, B, J and U formats
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module pipeDecode (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  stallD_i,
    input  logic                                  flushD_i,
    input  riscvPipePkg::fetchRegT                fetch_i,
    input  logic [2:0]                            immSrcD_i,
    output logic [6:0]                            opD_o,
    output logic [2:0]                            funct3D_o,
    output logic                                  funct7b5D_o,
    output logic [riscvPipePkg::regAddrBits-1:0]  rs1D_o,
    output logic [riscvPipePkg::regAddrBits-1:0]  rs2D_o,
    output logic [riscvPipePkg::regAddrBits-1:0]  rdD_o,
    output logic [riscvPipePkg::xlen-1:0]         pcD_o,
    output logic [riscvPipePkg::xlen-1:0]         pcPlus4D_o,
    output logic [riscvPipePkg::xlen-1:0]         extImmD_o
);

    riscvPipePkg::fetchRegT fetchD;

    always_ff @(posedge clk) begin
        if (reset || flushD_i) begin
            fetchD <= '0;
        end else if (!stallD_i) begin
            fetchD <= fetch_i;
        end
    end

    assign opD_o       = fetchD.instr.rView.opcode;
    assign funct3D_o   = fetchD.instr.rView.funct3;
    assign funct7b5D_o = fetchD.instr.rView.funct7[5];
    assign rs1D_o      = fetchD.instr.rView.rs1;
    assign rs2D_o      = fetchD.instr.rView.rs2;
    assign rdD_o       = fetchD.instr.rView.rd;
    assign pcD_o       = fetchD.pc;
    assign pcPlus4D_o  = fetchD.pcPlus4;

    // Register view for I, J and U; store view for S and B
    always_comb begin
        case (immSrcD_i)
            riscvPipePkg::immI: extImmD_o = {{20{fetchD.instr.rView.funct7[6]}},
                                             fetchD.instr.rView.funct7,
                                             fetchD.instr.rView.rs2};
            riscvPipePkg::immS: extImmD_o = {{20{fetchD.instr.sView.immHi[6]}},
                                             fetchD.instr.sView.immHi,
                                             fetchD.instr.sView.immLo};
            riscvPipePkg::immB: extImmD_o = {{20{fetchD.instr.sView.immHi[6]}},
                                             fetchD.instr.sView.immLo[0],
                                             fetchD.instr.sView.immHi[5:0],
                                             fetchD.instr.sView.immLo[4:1], 1'b0};
            riscvPipePkg::immJ: extImmD_o = {{12{fetchD.instr.rView.funct7[6]}},
                                             fetchD.instr.rView.rs1,
                                             fetchD.instr.rView.funct3,
                                             fetchD.instr.rView.rs2[0],
                                             fetchD.instr.rView.funct7[5:0],
                                             fetchD.instr.rView.rs2[4:1], 1'b0};
            riscvPipePkg::immU: extImmD_o = {fetchD.instr.rView.funct7,
                                             fetchD.instr.rView.rs2,
                                             fetchD.instr.rView.rs1,
                                             fetchD.instr.rView.funct3, 12'b0};
            default:            extImmD_o = '0;
        endcase
    end

endmodule

// ==== regFile.sv ====
////////////////////////////////////////////////////////////////////////////
// 32 x 32-bit register file, two reads and one write with write-through
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module regFile (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [riscvPipePkg::regAddrBits-1:0]  rs1_i,
    input  logic [riscvPipePkg::regAddrBits-1:0]  rs2_i,
    input  logic [riscvPipePkg::regAddrBits-1:0]  rd_i,
    input  logic                                  we_i,
    input  logic [riscvPipePkg::xlen-1:0]         wd_i,
    output logic [riscvPipePkg::xlen-1:0]         rd1_o,
    output logic [riscvPipePkg::xlen-1:0]         rd2_o
);

    logic [riscvPipePkg::xlen-1:0] regs [2**riscvPipePkg::regAddrBits];

    // x0 reads zero, a same-cycle write wins over the stored value
    function automatic logic [riscvPipePkg::xlen-1:0] readPort(
        input logic [riscvPipePkg::regAddrBits-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end else if (we_i && addr == rd_i) begin
            return wd_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rd1_o = readPort(rs1_i);
        rd2_o = readPort(rs2_i);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= wd_i;
        end
    end

endmodule

// ==== pipeExecute.sv ====
////////////////////////////////////////////////////////////////////////////
// Execute stage: register, forwarding and source muxes, ALU, and branch
// and jump resolution against a not-taken prediction
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module pipeExecute (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  flushE_i,
    input  riscvPipePkg::execRegT                 decode_i,
    input  riscvPipePkg::exCtrlT                  ctrl_i,
    input  logic [riscvPipePkg::xlen-1:0]         forwardDataM_i,
    input  logic [riscvPipePkg::xlen-1:0]         resultW_i,
    output logic [riscvPipePkg::regAddrBits-1:0]  rs1E_o,
    output logic [riscvPipePkg::regAddrBits-1:0]  rs2E_o,
    output logic [riscvPipePkg::regAddrBits-1:0]  rdE_o,
    output logic                                  zeroE_o,
    output logic [riscvPipePkg::xlen-1:0]         aluResultE_o,
    output logic [riscvPipePkg::xlen-1:0]         writeDataE_o,
    output logic [riscvPipePkg::xlen-1:0]         extImmE_o,
    output logic [riscvPipePkg::xlen-1:0]         pcPlus4E_o,
    output logic [riscvPipePkg::xlen-1:0]         pcTargetE_o,
    output logic                                  mispredict_o
);

    riscvPipePkg::execRegT execE;
    logic [riscvPipePkg::xlen-1:0] srcA;
    logic [riscvPipePkg::xlen-1:0] srcB;
    logic branchTaken;

    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            execE <= '0;
        end else begin
            execE <= decode_i;
        end
    end

    // Operand forwarding from memory and writeback
    always_comb begin
        case (ctrl_i.forwardA)
            riscvPipePkg::fwdMem: srcA = forwardDataM_i;
            riscvPipePkg::fwdWb:  srcA = resultW_i;
            default:              srcA = execE.rd1;
        endcase
        case (ctrl_i.forwardB)
            riscvPipePkg::fwdMem: writeDataE_o = forwardDataM_i;
            riscvPipePkg::fwdWb:  writeDataE_o = resultW_i;
            default:              writeDataE_o = execE.rd2;
        endcase
        srcB = ctrl_i.aluSrc ? execE.extImm : writeDataE_o;
    end

    always_comb begin
        case (ctrl_i.aluControl)
            riscvPipePkg::aluAdd: aluResultE_o = srcA + srcB;
            riscvPipePkg::aluSub: aluResultE_o = srcA - srcB;
            riscvPipePkg::aluAnd: aluResultE_o = srcA & srcB;
            riscvPipePkg::aluOr:  aluResultE_o = srcA | srcB;
            riscvPipePkg::aluSlt: aluResultE_o = {{(riscvPipePkg::xlen-1){1'b0}},
                                                  $signed(srcA) < $signed(srcB)};
            default:              aluResultE_o = '0;
        endcase
    end

    assign zeroE_o = (aluResultE_o == '0);

    // Fetch always guessed not taken, so any taken transfer redirects
    assign branchTaken = (execE.funct3 == riscvPipePkg::f3Beq && zeroE_o) ||
                         (execE.funct3 == riscvPipePkg::f3Bne && !zeroE_o);
    assign mispredict_o = (execE.op == riscvPipePkg::opBranch && branchTaken) ||
                          execE.op == riscvPipePkg::opJal ||
                          execE.op == riscvPipePkg::opJalr;
    assign pcTargetE_o = execE.pc + execE.extImm;

    assign rs1E_o     = execE.rs1;
    assign rs2E_o     = execE.rs2;
    assign rdE_o      = execE.rd;
    assign extImmE_o  = execE.extImm;
    assign pcPlus4E_o = execE.pcPlus4;

endmodule

// ==== pipeMemWb.sv ====
////////////////////////////////////////////////////////////////////////////
// Memory and writeback registers with forward data and result selection
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module pipeMemWb (
    input  logic                                  clk,
    input  logic                                  reset,
    input  riscvPipePkg::memRegT                  exec_i,
    input  logic [riscvPipePkg::xlen-1:0]         readDataM_i,
    input  riscvPipePkg::resCtrlT                 res_i,
    output logic [riscvPipePkg::xlen-1:0]         aluResultM_o,
    output logic [riscvPipePkg::xlen-1:0]         writeDataM_o,
    output logic [riscvPipePkg::xlen-1:0]         forwardDataM_o,
    output logic [riscvPipePkg::xlen-1:0]         resultW_o,
    output logic [riscvPipePkg::regAddrBits-1:0]  rdM_o,
    output logic [riscvPipePkg::regAddrBits-1:0]  rdW_o
);

    riscvPipePkg::memRegT memM;
    riscvPipePkg::memRegT memW;
    logic [riscvPipePkg::xlen-1:0] readDataW;

    always_ff @(posedge clk) begin
        if (reset) begin
            memM      <= '0;
            memW      <= '0;
            readDataW <= '0;
        end else begin
            memM      <= exec_i;
            memW      <= memM;
            readDataW <= readDataM_i;
        end
    end

    // Load data is not back yet, so memory forwards the other sources only
    always_comb begin
        case (res_i.resultSrcM)
            riscvPipePkg::resPcPlus4: forwardDataM_o = memM.pcPlus4;
            riscvPipePkg::resImm:     forwardDataM_o = memM.extImm;
            default:                  forwardDataM_o = memM.aluResult;
        endcase
    end

    always_comb begin
        case (res_i.resultSrcW)
            riscvPipePkg::resMem:     resultW_o = readDataW;
            riscvPipePkg::resPcPlus4: resultW_o = memW.pcPlus4;
            riscvPipePkg::resImm:     resultW_o = memW.extImm;
            default:                  resultW_o = memW.aluResult;
        endcase
    end

    assign aluResultM_o = memM.aluResult;
    assign writeDataM_o = memM.writeData;
    assign rdM_o        = memM.rd;
    assign rdW_o        = memW.rd;

endmodule

// ==== riscvDatapath.sv ====
////////////////////////////////////////////////////////////////////////////
// Five-stage RISC-V integer datapath, single issue, not-taken prediction
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module riscvDatapath (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  stallF_i,
    input  logic                                  stallD_i,
    input  logic                                  flushD_i,
    input  logic                                  flushE_i,
    input  logic [riscvPipePkg::xlen-1:0]         instrF_i,
    input  logic [2:0]                            immSrcD_i,
    input  riscvPipePkg::exCtrlT                  exCtrl_i,
    input  riscvPipePkg::resCtrlT                 resCtrl_i,
    input  logic [riscvPipePkg::xlen-1:0]         readDataM_i,
    output logic [riscvPipePkg::xlen-1:0]         pcF_o,
    output logic [6:0]                            opD_o,
    output logic [2:0]                            funct3D_o,
    output logic                                  funct7b5D_o,
    output logic [riscvPipePkg::regAddrBits-1:0]  rs1D_o,
    output logic [riscvPipePkg::regAddrBits-1:0]  rs2D_o,
    output logic [riscvPipePkg::regAddrBits-1:0]  rs1E_o,
    output logic [riscvPipePkg::regAddrBits-1:0]  rs2E_o,
    output logic [riscvPipePkg::regAddrBits-1:0]  rdE_o,
    output logic [riscvPipePkg::regAddrBits-1:0]  rdM_o,
    output logic [riscvPipePkg::regAddrBits-1:0]  rdW_o,
    output logic                                  zeroE_o,
    output logic                                  mispredict_o,
    output logic [riscvPipePkg::xlen-1:0]         aluResultM_o,
    output logic [riscvPipePkg::xlen-1:0]         writeDataM_o
);

    logic [riscvPipePkg::xlen-1:0] pcPlus4F, pcTargetE;
    logic [riscvPipePkg::xlen-1:0] pcD, pcPlus4D, extImmD, rd1D, rd2D;
    logic [riscvPipePkg::xlen-1:0] aluResultE, writeDataE, extImmE, pcPlus4E;
    logic [riscvPipePkg::xlen-1:0] forwardDataM, resultW;
    logic [riscvPipePkg::regAddrBits-1:0] rdD;
    riscvPipePkg::fetchRegT fetchF;
    riscvPipePkg::execRegT decodeOut;
    riscvPipePkg::memRegT execOut;

    // Stage bundles
    assign fetchF    = {instrF_i, pcF_o, pcPlus4F};
    assign decodeOut = {rd1D, rd2D, pcD, pcPlus4D, extImmD, rs1D_o, rs2D_o, rdD,
                        opD_o, funct3D_o};
    assign execOut   = {aluResultE, writeDataE, extImmE, pcPlus4E, rdE_o};

    pipeFetch fetch0 (
        .clk(clk), .reset(reset), .stallF_i(stallF_i), .mispredict_i(mispredict_o),
        .pcTarget_i(pcTargetE), .pcF_o(pcF_o), .pcPlus4F_o(pcPlus4F)
    );

    pipeDecode decode0 (
        .clk(clk), .reset(reset), .stallD_i(stallD_i), .flushD_i(flushD_i),
        .fetch_i(fetchF), .immSrcD_i(immSrcD_i), .opD_o(opD_o),
        .funct3D_o(funct3D_o), .funct7b5D_o(funct7b5D_o), .rs1D_o(rs1D_o),
        .rs2D_o(rs2D_o), .rdD_o(rdD), .pcD_o(pcD), .pcPlus4D_o(pcPlus4D),
        .extImmD_o(extImmD)
    );

    regFile rf0 (
        .clk(clk), .reset(reset), .rs1_i(rs1D_o), .rs2_i(rs2D_o), .rd_i(rdW_o),
        .we_i(resCtrl_i.regWriteW), .wd_i(resultW), .rd1_o(rd1D), .rd2_o(rd2D)
    );

    pipeExecute execute0 (
        .clk(clk), .reset(reset), .flushE_i(flushE_i), .decode_i(decodeOut),
        .ctrl_i(exCtrl_i), .forwardDataM_i(forwardDataM), .resultW_i(resultW),
        .rs1E_o(rs1E_o), .rs2E_o(rs2E_o), .rdE_o(rdE_o), .zeroE_o(zeroE_o),
        .aluResultE_o(aluResultE), .writeDataE_o(writeDataE), .extImmE_o(extImmE),
        .pcPlus4E_o(pcPlus4E), .pcTargetE_o(pcTargetE), .mispredict_o(mispredict_o)
    );

    pipeMemWb memWb0 (
        .clk(clk), .reset(reset), .exec_i(execOut), .readDataM_i(readDataM_i),
        .res_i(resCtrl_i), .aluResultM_o(aluResultM_o), .writeDataM_o(writeDataM_o),
        .forwardDataM_o(forwardDataM), .resultW_o(resultW), .rdM_o(rdM_o),
        .rdW_o(rdW_o)
    );

endmodule

// ==== riscvDatapathTb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the five-stage datapath: plays the outside controller and
// hazard unit, runs a short program and checks against a reference model
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module riscvDatapathTb;

    localparam int progLen = 20;
    localparam int resetCycles = 16;
    localparam int cycleLimit = 10 * progLen + resetCycles;

    // One pipeline slot of the reference model
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] alu;
        logic [31:0] wdata;
        logic [31:0] target;
        logic        taken;
    } stageT;

    logic clk;
    logic reset;
    logic stallF, stallD, flushD, flushE;
    logic [31:0] instrF;
    logic [2:0] immSrcD;
    riscvPipePkg::exCtrlT exCtrl;
    riscvPipePkg::resCtrlT resCtrl;
    logic [31:0] readDataM;
    logic [31:0] pcF, aluResultM, writeDataM;
    logic [6:0] opD;
    logic [2:0] funct3D;
    logic funct7b5D, zeroE, mispredict;
    logic [4:0] rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;

    logic [31:0] imem [64];
    logic [31:0] model [32];
    logic [31:0] pcModel;
    stageT stD, stE, stM, stW;
    integer seed = 32'h34070ba9;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int runCycle = 0;

    riscvDatapath dut0 (
        .clk(clk), .reset(reset), .stallF_i(stallF), .stallD_i(stallD),
        .flushD_i(flushD), .flushE_i(flushE), .instrF_i(instrF), .immSrcD_i(immSrcD),
        .exCtrl_i(exCtrl), .resCtrl_i(resCtrl), .readDataM_i(readDataM), .pcF_o(pcF),
        .opD_o(opD), .funct3D_o(funct3D), .funct7b5D_o(funct7b5D), .rs1D_o(rs1D),
        .rs2D_o(rs2D), .rs1E_o(rs1E), .rs2E_o(rs2E), .rdE_o(rdE), .rdM_o(rdM),
        .rdW_o(rdW), .zeroE_o(zeroE), .mispredict_o(mispredict),
        .aluResultM_o(aluResultM), .writeDataM_o(writeDataM)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, riscvPipePkg::opOpImm};
    endfunction

    function automatic logic [31:0] encR(input logic f7b5, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {1'b0, f7b5, 5'b0, rs2, rs1, f3, rd, riscvPipePkg::opOp};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], riscvPipePkg::opBranch};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, riscvPipePkg::opJal};
    endfunction

    // Immediates as the RISC-V spec lays them out
    function automatic logic [31:0] immOf(input logic [31:0] in);
        case (in[6:0])
            riscvPipePkg::opOpImm:  return {{20{in[31]}}, in[31:20]};
            riscvPipePkg::opBranch: return {{19{in[31]}}, in[31], in[7], in[30:25],
                                            in[11:8], 1'b0};
            riscvPipePkg::opJal:    return {{11{in[31]}}, in[31], in[19:12], in[20],
                                            in[30:21], 1'b0};
            default:                return 32'd0;
        endcase
    endfunction

    function automatic logic [2:0] immSelOf(input logic [6:0] op);
        case (op)
            riscvPipePkg::opBranch: return riscvPipePkg::immB;
            riscvPipePkg::opJal:    return riscvPipePkg::immJ;
            default:                return riscvPipePkg::immI;
        endcase
    endfunction

    function automatic logic [2:0] aluCtrlOf(input logic [31:0] in);
        if (in[6:0] == riscvPipePkg::opBranch) begin
            return riscvPipePkg::aluSub;
        end else if (in[6:0] != riscvPipePkg::opOp && in[6:0] != riscvPipePkg::opOpImm) begin
            return riscvPipePkg::aluAdd;
        end
        case (in[14:12])
            3'b111:  return riscvPipePkg::aluAnd;
            3'b110:  return riscvPipePkg::aluOr;
            3'b010:  return riscvPipePkg::aluSlt;
            default: return (in[6:0] == riscvPipePkg::opOp && in[30]) ?
                            riscvPipePkg::aluSub : riscvPipePkg::aluAdd;
        endcase
    endfunction

    function automatic logic writesReg(input logic [31:0] in);
        return in[6:0] == riscvPipePkg::opOp || in[6:0] == riscvPipePkg::opOpImm ||
               in[6:0] == riscvPipePkg::opJal;
    endfunction

    // Hazard unit choice for one source register
    function automatic logic [1:0] forwardOf(input logic [4:0] rs);
        if (rs != 5'd0 && writesReg(stM.instr) && stM.instr[11:7] == rs) begin
            return riscvPipePkg::fwdMem;
        end else if (rs != 5'd0 && writesReg(stW.instr) && stW.instr[11:7] == rs) begin
            return riscvPipePkg::fwdWb;
        end
        return riscvPipePkg::fwdReg;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("MISMATCH %s got %h expected %h at cycle %0d", name, got, exp, cycles);
        end
    endtask

    task automatic loadProgram();
        logic [11:0] immA;
        logic [11:0] immB;
        immA = 12'($random(seed));
        immB = 12'($random(seed));
        for (int i = 0; i < 64; i++) begin
            imem[i] = encI(12'(i * 37 + 5), 5'd0, 3'b000, 5'd0);
        end
        imem[0]  = encI(immA | 12'd1, 5'd0, 3'b000, 5'd1);
        imem[1]  = encI(immB, 5'd0, 3'b000, 5'd2);
        imem[2]  = encR(1'b0, 5'd2, 5'd1, 3'b000, 5'd3);
        imem[3]  = encR(1'b1, 5'd1, 5'd3, 3'b000, 5'd4);
        imem[4]  = encI(12'($random(seed)), 5'd4, 3'b111, 5'd5);
        imem[5]  = encI(12'($random(seed)), 5'd5, 3'b110, 5'd6);
        imem[6]  = encI(12'($random(seed)), 5'd6, 3'b010, 5'd7);
        imem[7]  = encR(1'b0, 5'd2, 5'd1, 3'b010, 5'd8);
        imem[8]  = encI(12'd5, 5'd1, 3'b000, 5'd0);
        imem[9]  = encR(1'b0, 5'd0, 5'd2, 3'b000, 5'd9);
        imem[10] = encB(13'd8, 5'd1, 5'd1, riscvPipePkg::f3Beq);
        imem[12] = encB(13'd8, 5'd0, 5'd1, riscvPipePkg::f3Bne);
        imem[14] = encB(13'd8, 5'd0, 5'd1, riscvPipePkg::f3Beq);
        imem[15] = encJ(21'd8, 5'd11);
        imem[17] = encR(1'b0, 5'd0, 5'd11, 3'b000, 5'd12);
        imem[18] = encR(1'b0, 5'd4, 5'd3, 3'b110, 5'd13);
        // x12 is still in writeback here, x13 in memory
        imem[19] = encR(1'b0, 5'd13, 5'd12, 3'b000, 5'd14);
    endtask

    // Resolve the instruction now in execute in program order
    task automatic computeExecute();
        logic [31:0] a;
        logic [31:0] rs2v;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        imm = immOf(stE.instr);
        a = model[stE.instr[19:15]];
        rs2v = model[stE.instr[24:20]];
        b = (stE.instr[6:0] == riscvPipePkg::opOpImm) ? imm : rs2v;
        case (aluCtrlOf(stE.instr))
            riscvPipePkg::aluSub: res = a - b;
            riscvPipePkg::aluAnd: res = a & b;
            riscvPipePkg::aluOr:  res = a | b;
            riscvPipePkg::aluSlt: res = {31'd0, $signed(a) < $signed(b)};
            default:              res = a + b;
        endcase
        stE.alu = res;
        stE.wdata = rs2v;
        stE.target = stE.pc + imm;
        stE.taken = (stE.instr[6:0] == riscvPipePkg::opJal) ||
                    (stE.instr[6:0] == riscvPipePkg::opBranch &&
                     ((stE.instr[14:12] == riscvPipePkg::f3Beq && res == 32'd0) ||
                      (stE.instr[14:12] == riscvPipePkg::f3Bne && res != 32'd0)));
        if (writesReg(stE.instr) && stE.instr[11:7] != 5'd0) begin
            model[stE.instr[11:7]] = (stE.instr[6:0] == riscvPipePkg::opJal) ?
                                     stE.pc + 32'd4 : res;
        end
    endtask

    // Controller and hazard unit outputs for this cycle
    task automatic driveCycle();
        logic stallNow;
        stallNow = (runCycle == 3 || runCycle == 4);
        computeExecute();
        instrF = imem[pcModel[7:2]];
        immSrcD = immSelOf(stD.instr[6:0]);
        exCtrl.aluSrc = (stE.instr[6:0] == riscvPipePkg::opOpImm);
        exCtrl.aluControl = aluCtrlOf(stE.instr);
        exCtrl.forwardA = forwardOf(stE.instr[19:15]);
        exCtrl.forwardB = forwardOf(stE.instr[24:20]);
        resCtrl.resultSrcM = (stM.instr[6:0] == riscvPipePkg::opJal) ?
                             riscvPipePkg::resPcPlus4 : riscvPipePkg::resAlu;
        resCtrl.resultSrcW = (stW.instr[6:0] == riscvPipePkg::opJal) ?
                             riscvPipePkg::resPcPlus4 : riscvPipePkg::resAlu;
        resCtrl.regWriteW = writesReg(stW.instr);
        stallF = stallNow;
        stallD = stallNow;
        flushE = stallNow || stE.taken;
        flushD = stE.taken && !stallNow;
        runCycle++;
    endtask

    // Checks on pre-edge values, then the model steps with the DUT
    always @(posedge clk) begin
        cycles++;
        if (!reset) begin
            checkValue("pcF_o", pcF, pcModel);
            checkValue("mispredict_o", {31'd0, mispredict}, {31'd0, stE.taken});
            checkValue("aluResultM_o", aluResultM, stM.alu);
            checkValue("writeDataM_o", writeDataM, stM.wdata);
            checkValue("rdW_o", {27'd0, rdW}, {27'd0, stW.instr[11:7]});
            // Decode fields of the held instruction word
            checkValue("opD_o", {25'd0, opD}, {25'd0, stD.instr[6:0]});
            checkValue("funct3D_o", {29'd0, funct3D}, {29'd0, stD.instr[14:12]});
            checkValue("funct7b5D_o", {31'd0, funct7b5D}, {31'd0, stD.instr[30]});
            checkValue("rs1D_o", {27'd0, rs1D}, {27'd0, stD.instr[19:15]});
            checkValue("rs2D_o", {27'd0, rs2D}, {27'd0, stD.instr[24:20]});
            checkValue("rs1E_o", {27'd0, rs1E}, {27'd0, stE.instr[19:15]});
            checkValue("rs2E_o", {27'd0, rs2E}, {27'd0, stE.instr[24:20]});
            checkValue("rdE_o", {27'd0, rdE}, {27'd0, stE.instr[11:7]});
            checkValue("rdM_o", {27'd0, rdM}, {27'd0, stM.instr[11:7]});
            checkValue("zeroE_o", {31'd0, zeroE}, {31'd0, stE.alu == 32'd0});
            stW = stM;
            stM = stE;
            if (stallF) begin
                stE = '0;
            end else if (stE.taken) begin
                pcModel = stE.target;
                stE = '0;
                stD = '0;
            end else begin
                stE = stD;
                stD = '0;
                stD.instr = imem[pcModel[7:2]];
                stD.pc = pcModel;
                pcModel = pcModel + 32'd4;
            end
        end
        if (cycles > cycleLimit) begin
            $display("Timeout: program did not finish within %0d cycles", cycleLimit);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        stallF = 1'b0;
        stallD = 1'b0;
        flushD = 1'b0;
        flushE = 1'b0;
        instrF = 32'd0;
        immSrcD = riscvPipePkg::immI;
        exCtrl = '0;
        resCtrl = '0;
        readDataM = 32'd0;
        pcModel = riscvPipePkg::pcStart;
        stD = '0;
        stE = '0;
        stM = '0;
        stW = '0;
        for (int i = 0; i < 32; i++) begin
            model[i] = 32'd0;
        end
        loadProgram();
        repeat (resetCycles) @(negedge clk);
        reset = 1'b0;
        driveCycle();
        while (pcModel < 32'(progLen * 4)) begin
            @(negedge clk);
            driveCycle();
        end
        // Drain the last instructions through writeback
        repeat (6) begin
            @(negedge clk);
            driveCycle();
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== riscvDatapath.f ====
riscvPipePkg.sv
pipeFetch.sv
pipeDecode.sv
regFile.sv
pipeExecute.sv
pipeMemWb.sv
riscvDatapath.sv
riscvDatapathTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = riscvDatapathTb
FILELIST = riscvDatapath.f
OBJDIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJDIR)
